// ==== logic/fdc_pkg.sv ====
/*
 * shared definitions for the floppy controller command path
 * command opcodes, sequencer states, bus and drive structs,
 * step timer, result FIFO and status register constants
 */

package fdc_pkg;

	// ==================================================================
	// encodings
	// ==================================================================

	// low five bits of the command byte
	typedef enum logic [4:0] {
		OP_SPECIFY     = 5'h03,
		OP_SENSE_DRIVE = 5'h04,
		OP_RECALIBRATE = 5'h07,
		OP_SENSE_INT   = 5'h08,
		OP_SEEK        = 5'h0F
	} fdc_opcode_e;

	typedef enum logic [2:0] {
		SEQ_IDLE,
		SEQ_SPEC_P1,     // step rate / head unload byte
		SEQ_SPEC_P2,     // head load byte, discarded
		SEQ_SDRV_P,
		SEQ_RECAL_P,
		SEQ_SEEK_DRV,
		SEQ_SEEK_CYL,
		SEQ_EXEC         // results being pushed
	} seq_state_e;

	// ==================================================================
	// structs
	// ==================================================================

	typedef struct packed {
		logic       strobe;
		logic [7:0] data;
	} host_byte_t;

	typedef struct packed {
		logic       strobe;
		logic       drive;
		logic [7:0] target;   // 0 for recalibrate
	} seek_cmd_t;

	typedef struct packed {
		logic       ready;
		logic       write_protect;
		logic       two_sided;
		logic [7:0] track_count;
	} drive_info_t;

	typedef struct packed {
		logic [7:0] pcn;      // present cylinder
		logic       busy;
		logic       int_pending;
		logic       seek_ok;
	} drive_seek_t;

	// ==================================================================
	// constants
	// ==================================================================

	localparam int STEP_CYCLES_PER_MS = 4000;
	localparam int STEP_PRESCALE_W    = $clog2(STEP_CYCLES_PER_MS);

	localparam int RESULT_FIFO_DEPTH = 8;
	localparam int RESULT_PTR_W      = 3;

	// main status register bits
	localparam int MSR_D0B = 0;
	localparam int MSR_D1B = 1;
	localparam int MSR_CB  = 4;
	localparam int MSR_DIO = 6;
	localparam int MSR_RQM = 7;

	localparam logic [7:0] ST0_INVALID       = 8'h80;
	localparam logic [7:0] ST0_SEEK_END      = 8'h20;
	localparam logic [7:0] ST0_ABNORMAL_SEEK = 8'hE8;

endpackage

// ==== logic/fdc_host_port.sv ====
/*
 * host bus port
 * read/write line sync and falling edge detect, one strobe per access,
 * read mux between status, result FIFO head and FF
 */

`timescale 1ns/1ps

module fdc_host_port (
	input  logic                i_clk_sys,
	input  logic                i_reset,
	input  logic                i_a0,
	input  logic                i_rd_n,
	input  logic                i_wr_n,
	input  logic [7:0]          i_din,
	input  logic [7:0]          i_msr,
	input  logic [7:0]          i_fifo_data,
	input  logic                i_fifo_not_empty,
	output logic [7:0]          o_dout,
	output fdc_pkg::host_byte_t o_cmd,
	output logic                o_fifo_pop
);

	logic       rd_q1, rd_q2;
	logic       wr_q1, wr_q2;
	logic       a0_q;
	logic [7:0] din_q;
	logic       rd_fall, wr_fall;

	always_ff @(posedge i_clk_sys) begin
		if (i_reset) begin
			rd_q1 <= 1'b1;   // bus idles high
			rd_q2 <= 1'b1;
			wr_q1 <= 1'b1;
			wr_q2 <= 1'b1;
		end else begin
			rd_q1 <= i_rd_n;
			rd_q2 <= rd_q1;
			wr_q1 <= i_wr_n;
			wr_q2 <= wr_q1;
		end
	end

	// address and data sampled alongside the strobes
	always_ff @(posedge i_clk_sys) begin
		a0_q  <= i_a0;
		din_q <= i_din;
	end

	assign rd_fall = rd_q2 & ~rd_q1;
	assign wr_fall = wr_q2 & ~wr_q1;

	assign o_cmd.strobe = wr_fall & a0_q;   // a0 low writes go nowhere
	assign o_cmd.data   = din_q;
	assign o_fifo_pop   = rd_fall & a0_q & i_fifo_not_empty;

	always_ff @(posedge i_clk_sys) begin
		if (i_reset) begin
			o_dout <= 8'h00;
		end else if (rd_fall) begin
			if (!a0_q)
				o_dout <= i_msr;
			else if (i_fifo_not_empty)
				o_dout <= i_fifo_data;
			else
				o_dout <= 8'hFF;   // read past end of results
		end
	end

endmodule

// ==== logic/fdc_result_fifo.sv ====
/*
 * result byte queue
 * circular buffer between the command sequencer and the host port
 */

`timescale 1ns/1ps

module fdc_result_fifo (
	input  logic       i_clk_sys,
	input  logic       i_reset,
	input  logic       i_push,
	input  logic [7:0] i_push_data,
	input  logic       i_pop,
	output logic [7:0] o_head,
	output logic       o_not_empty
);

	logic [7:0]                       mem [fdc_pkg::RESULT_FIFO_DEPTH];
	logic [fdc_pkg::RESULT_PTR_W-1:0] wr_ptr, rd_ptr;
	logic [fdc_pkg::RESULT_PTR_W:0]   count;
	logic                             do_push, do_pop;

	// full push and empty pop are dropped
	assign do_push = i_push &&
		(count != (fdc_pkg::RESULT_PTR_W + 1)'(fdc_pkg::RESULT_FIFO_DEPTH));
	assign do_pop  = i_pop && (count != '0);

	always_ff @(posedge i_clk_sys) begin
		if (do_push)
			mem[wr_ptr] <= i_push_data;
	end

	always_ff @(posedge i_clk_sys) begin
		if (i_reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;   // depth is a power of two, wraps itself
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign o_head      = mem[rd_ptr];
	assign o_not_empty = (count != '0);

endmodule

// ==== logic/fdc_command_sequencer.sv ====
/*
 * command sequencer
 * opcode decode, parameter collection, result byte generation
 * for sense interrupt, sense drive and invalid commands,
 * seek/specify requests to the seek engine, main status byte
 */

`timescale 1ns/1ps

module fdc_command_sequencer (
	input  logic                       i_clk_sys,
	input  logic                       i_reset,
	input  fdc_pkg::host_byte_t        i_cmd,
	input  logic                       i_fifo_not_empty,
	input  fdc_pkg::drive_info_t [1:0] i_drive,
	input  fdc_pkg::drive_seek_t [1:0] i_seek_stat,
	output logic                       o_push,
	output logic [7:0]                 o_push_data,
	output fdc_pkg::seek_cmd_t         o_seek,
	output logic                       o_srt_load,
	output logic [3:0]                 o_srt,
	output logic                       o_int_ack,
	output logic                       o_int_ack_drive,
	output logic                       o_int_clear_all,
	output logic [7:0]                 o_msr
);

	fdc_pkg::seq_state_e  state;
	fdc_pkg::fdc_opcode_e opcode;
	logic                 seek_drv;    // drive byte of a seek
	logic [7:0]           res0, res1;  // res0 is next to push
	logic [1:0]           res_cnt;

	// sense interrupt result, picked from the pending flags
	logic                 si_any, si_drv;
	logic [7:0]           si_st0, si_pcn;
	// sense drive status result
	logic                 sd_drv;
	fdc_pkg::drive_info_t sd_info;
	logic [7:0]           sd_byte;

	assign opcode = fdc_pkg::fdc_opcode_e'(i_cmd.data[4:0]);

	always_comb begin
		si_any = i_seek_stat[0].int_pending | i_seek_stat[1].int_pending;
		si_drv = ~i_seek_stat[0].int_pending;   // drive 0 wins
		si_pcn = i_seek_stat[si_drv].pcn;
		if (!si_any)
			si_st0 = fdc_pkg::ST0_INVALID;
		else if (i_seek_stat[si_drv].seek_ok)
			si_st0 = fdc_pkg::ST0_SEEK_END | {7'd0, si_drv};
		else
			si_st0 = fdc_pkg::ST0_ABNORMAL_SEEK | {7'd0, si_drv};
	end

	always_comb begin
		sd_drv  = i_cmd.data[0];
		sd_info = i_drive[sd_drv];
		sd_byte = {1'b0,
			sd_info.write_protect & sd_info.ready,          // wp
			sd_info.ready,                                  // ready
			sd_info.ready & (i_seek_stat[sd_drv].pcn == 8'd0), // track 0
			sd_info.ready & sd_info.two_sided,              // two side
			2'b00,                                          // head, us1
			sd_drv};
	end

	// ==================================================================
	// command FSM
	// ==================================================================

	always_ff @(posedge i_clk_sys) begin
		if (i_reset) begin
			state           <= fdc_pkg::SEQ_IDLE;
			res_cnt         <= 2'd0;
			seek_drv        <= 1'b0;
			o_seek          <= '0;
			o_srt_load      <= 1'b0;
			o_srt           <= 4'd0;
			o_int_ack       <= 1'b0;
			o_int_ack_drive <= 1'b0;
			o_int_clear_all <= 1'b0;
		end else begin
			// strobes last one cycle
			o_seek.strobe   <= 1'b0;
			o_srt_load      <= 1'b0;
			o_int_ack       <= 1'b0;
			o_int_clear_all <= 1'b0;

			case (state)
				fdc_pkg::SEQ_IDLE:
				if (i_cmd.strobe && !i_fifo_not_empty) begin
					case (opcode)
						fdc_pkg::OP_SPECIFY: begin
							o_int_clear_all <= 1'b1;
							state           <= fdc_pkg::SEQ_SPEC_P1;
						end
						fdc_pkg::OP_SENSE_DRIVE: begin
							o_int_clear_all <= 1'b1;
							state           <= fdc_pkg::SEQ_SDRV_P;
						end
						fdc_pkg::OP_RECALIBRATE: begin
							o_int_clear_all <= 1'b1;
							state           <= fdc_pkg::SEQ_RECAL_P;
						end
						fdc_pkg::OP_SEEK: begin
							o_int_clear_all <= 1'b1;
							state           <= fdc_pkg::SEQ_SEEK_DRV;
						end
						fdc_pkg::OP_SENSE_INT: begin
							res0            <= si_st0;
							res1            <= si_pcn;
							res_cnt         <= si_any ? 2'd2 : 2'd1;
							o_int_ack       <= si_any;
							o_int_ack_drive <= si_drv;
							state           <= fdc_pkg::SEQ_EXEC;
						end
						default: begin   // anything else is invalid
							res0    <= fdc_pkg::ST0_INVALID;
							res_cnt <= 2'd1;
							state   <= fdc_pkg::SEQ_EXEC;
						end
					endcase
				end

				fdc_pkg::SEQ_SPEC_P1:
				if (i_cmd.strobe) begin
					o_srt      <= i_cmd.data[7:4];   // step rate nibble
					o_srt_load <= 1'b1;
					state      <= fdc_pkg::SEQ_SPEC_P2;
				end

				fdc_pkg::SEQ_SPEC_P2:
				if (i_cmd.strobe)
					state <= fdc_pkg::SEQ_IDLE;

				fdc_pkg::SEQ_SDRV_P:
				if (i_cmd.strobe) begin
					res0    <= sd_byte;
					res_cnt <= 2'd1;
					state   <= fdc_pkg::SEQ_EXEC;
				end

				fdc_pkg::SEQ_RECAL_P:
				if (i_cmd.strobe) begin
					o_seek <= '{strobe: 1'b1, drive: i_cmd.data[0], target: 8'd0};
					state  <= fdc_pkg::SEQ_IDLE;
				end

				fdc_pkg::SEQ_SEEK_DRV:
				if (i_cmd.strobe) begin
					seek_drv <= i_cmd.data[0];
					state    <= fdc_pkg::SEQ_SEEK_CYL;
				end

				fdc_pkg::SEQ_SEEK_CYL:
				if (i_cmd.strobe) begin
					o_seek <= '{strobe: 1'b1, drive: seek_drv, target: i_cmd.data};
					state  <= fdc_pkg::SEQ_IDLE;
				end

				fdc_pkg::SEQ_EXEC: begin
					res0    <= res1;   // shift next byte down
					res_cnt <= res_cnt - 2'd1;
					if (res_cnt == 2'd1)
						state <= fdc_pkg::SEQ_IDLE;
				end

				default: state <= fdc_pkg::SEQ_IDLE;
			endcase
		end
	end

	assign o_push      = (state == fdc_pkg::SEQ_EXEC);
	assign o_push_data = res0;

	always_comb begin
		o_msr = 8'h00;
		o_msr[fdc_pkg::MSR_D0B] = i_seek_stat[0].busy;
		o_msr[fdc_pkg::MSR_D1B] = i_seek_stat[1].busy;
		o_msr[fdc_pkg::MSR_CB]  = (state != fdc_pkg::SEQ_IDLE) | i_fifo_not_empty;
		o_msr[fdc_pkg::MSR_DIO] = i_fifo_not_empty;
		o_msr[fdc_pkg::MSR_RQM] = (state != fdc_pkg::SEQ_EXEC);
	end

endmodule

// ==== logic/fdc_seek_engine.sv ====
/*
 * seek engine
 * shared millisecond step timer, per drive cylinder tracking,
 * busy and interrupt flags for two drives
 */

`timescale 1ns/1ps

module fdc_seek_engine (
	input  logic                       i_clk_sys,
	input  logic                       i_reset,
	input  fdc_pkg::seek_cmd_t         i_seek,
	input  logic                       i_srt_load,
	input  logic [3:0]                 i_srt,
	input  logic                       i_int_ack,
	input  logic                       i_int_ack_drive,
	input  logic                       i_int_clear_all,
	input  fdc_pkg::drive_info_t [1:0] i_drive,
	output fdc_pkg::drive_seek_t [1:0] o_stat
);

	logic [fdc_pkg::STEP_PRESCALE_W-1:0] prescale;
	logic [3:0]                          srt;
	logic [3:0]                          ms_cnt;
	logic                                ms_tick, step_tick;

	logic [7:0] pcn [2];
	logic [7:0] ncn [2];   // target cylinder
	logic       busy [2];
	logic       int_pend [2];

	function automatic logic seek_valid(input fdc_pkg::drive_info_t info,
	                                    input logic [7:0] target);
		return (target == 8'd0) || (info.ready && (target < info.track_count));
	endfunction

	// ==================================================================
	// step timer, 16 - srt ms per step
	// ==================================================================

	assign ms_tick = (prescale ==
		(fdc_pkg::STEP_PRESCALE_W)'(fdc_pkg::STEP_CYCLES_PER_MS - 1));
	assign step_tick = ms_tick && (ms_cnt == 4'hF);

	always_ff @(posedge i_clk_sys) begin
		if (i_reset) begin
			prescale <= '0;
			srt      <= 4'd0;
			ms_cnt   <= 4'd0;
		end else if (i_srt_load) begin
			prescale <= '0;
			srt      <= i_srt;
			ms_cnt   <= i_srt;
		end else if (ms_tick) begin
			prescale <= '0;
			ms_cnt   <= (ms_cnt == 4'hF) ? srt : ms_cnt + 4'd1;
		end else begin
			prescale <= prescale + 1'b1;
		end
	end

	// ==================================================================
	// per drive seek, both drives in parallel
	// ==================================================================

	always_ff @(posedge i_clk_sys) begin
		for (int d = 0; d < 2; d++) begin
			if (i_reset) begin
				pcn[d]      <= 8'd0;
				ncn[d]      <= 8'd0;
				busy[d]     <= 1'b0;
				int_pend[d] <= 1'b0;
			end else begin
				if (i_int_clear_all || (i_int_ack && i_int_ack_drive == 1'(d)))
					int_pend[d] <= 1'b0;

				if (i_seek.strobe && i_seek.drive == 1'(d)) begin
					ncn[d] <= i_seek.target;
					if (seek_valid(i_drive[d], i_seek.target)) begin
						busy[d]     <= 1'b1;
						int_pend[d] <= 1'b0;
					end else begin
						busy[d]     <= 1'b0;
						int_pend[d] <= 1'b1;   // reports abnormal end
					end
				end else if (busy[d]) begin
					if (pcn[d] == ncn[d]) begin
						busy[d]     <= 1'b0;
						int_pend[d] <= 1'b1;
					end else if (step_tick) begin
						pcn[d] <= (pcn[d] > ncn[d]) ? pcn[d] - 8'd1 : pcn[d] + 8'd1;
					end
				end
			end
		end
	end

	always_comb begin
		for (int d = 0; d < 2; d++) begin
			o_stat[d].pcn         = pcn[d];
			o_stat[d].busy        = busy[d];
			o_stat[d].int_pending = int_pend[d];
			o_stat[d].seek_ok     = (pcn[d] == ncn[d]) && i_drive[d].ready;
		end
	end

endmodule

// ==== logic/fdc_ctrl_top.sv ====
/*
 * floppy controller command path top level
 * host port, command sequencer, result FIFO and seek engine
 */

`timescale 1ns/1ps

module fdc_ctrl_top (
	input  logic                       i_clk_sys,
	input  logic                       i_reset,
	input  logic                       i_a0,
	input  logic                       i_rd_n,
	input  logic                       i_wr_n,
	input  logic [7:0]                 i_din,
	input  fdc_pkg::drive_info_t [1:0] i_drive,
	output logic [7:0]                 o_dout
);

	fdc_pkg::host_byte_t        cmd;
	fdc_pkg::seek_cmd_t         seek;
	fdc_pkg::drive_seek_t [1:0] seek_stat;
	logic [7:0]                 msr;
	logic [7:0]                 fifo_head;
	logic                       fifo_not_empty;
	logic                       fifo_pop;
	logic                       push;
	logic [7:0]                 push_data;
	logic                       srt_load;
	logic [3:0]                 srt;
	logic                       int_ack, int_ack_drive, int_clear_all;

	fdc_host_port i_fdc_host_port (
		.i_clk_sys        (i_clk_sys),
		.i_reset          (i_reset),
		.i_a0             (i_a0),
		.i_rd_n           (i_rd_n),
		.i_wr_n           (i_wr_n),
		.i_din            (i_din),
		.i_msr            (msr),
		.i_fifo_data      (fifo_head),
		.i_fifo_not_empty (fifo_not_empty),
		.o_dout           (o_dout),
		.o_cmd            (cmd),
		.o_fifo_pop       (fifo_pop)
	);

	fdc_command_sequencer i_fdc_command_sequencer (
		.i_clk_sys        (i_clk_sys),
		.i_reset          (i_reset),
		.i_cmd            (cmd),
		.i_fifo_not_empty (fifo_not_empty),
		.i_drive          (i_drive),
		.i_seek_stat      (seek_stat),
		.o_push           (push),
		.o_push_data      (push_data),
		.o_seek           (seek),
		.o_srt_load       (srt_load),
		.o_srt            (srt),
		.o_int_ack        (int_ack),
		.o_int_ack_drive  (int_ack_drive),
		.o_int_clear_all  (int_clear_all),
		.o_msr            (msr)
	);

	fdc_result_fifo i_fdc_result_fifo (
		.i_clk_sys   (i_clk_sys),
		.i_reset     (i_reset),
		.i_push      (push),
		.i_push_data (push_data),
		.i_pop       (fifo_pop),
		.o_head      (fifo_head),
		.o_not_empty (fifo_not_empty)
	);

	fdc_seek_engine i_fdc_seek_engine (
		.i_clk_sys       (i_clk_sys),
		.i_reset         (i_reset),
		.i_seek          (seek),
		.i_srt_load      (srt_load),
		.i_srt           (srt),
		.i_int_ack       (int_ack),
		.i_int_ack_drive (int_ack_drive),
		.i_int_clear_all (int_clear_all),
		.i_drive         (i_drive),
		.o_stat          (seek_stat)
	);

endmodule

// ==== tb/fdc_ctrl_asserts.sv ====
/*
 * concurrent checks on the result FIFO
 * bound into fdc_result_fifo, failures counted for the testbench
 */

`timescale 1ns/1ps

module fdc_ctrl_asserts (
	input logic                           i_clk_sys,
	input logic                           i_reset,
	input logic                           i_push,
	input logic                           i_pop,
	input logic [fdc_pkg::RESULT_PTR_W:0] i_count
);

	int assert_errors = 0;   // read by the testbench at the end

	push_when_full: assert property (@(posedge i_clk_sys) disable iff (i_reset)
		!(i_push && i_count == fdc_pkg::RESULT_FIFO_DEPTH))
	else begin
		$error("result FIFO pushed while full");
		assert_errors++;
	end

	pop_when_empty: assert property (@(posedge i_clk_sys) disable iff (i_reset)
		!(i_pop && i_count == 0))
	else begin
		$error("result FIFO popped while empty");
		assert_errors++;
	end

	count_in_range: assert property (@(posedge i_clk_sys) disable iff (i_reset)
		i_count <= fdc_pkg::RESULT_FIFO_DEPTH)
	else begin
		$error("result FIFO count above depth");
		assert_errors++;
	end

endmodule

bind fdc_result_fifo fdc_ctrl_asserts i_fdc_ctrl_asserts (
	.i_clk_sys (i_clk_sys),
	.i_reset   (i_reset),
	.i_push    (i_push),
	.i_pop     (i_pop),
	.i_count   (count)
);

// ==== tb/fdc_ctrl_tb.sv ====
/*
 * testbench for the floppy controller command path
 * clock, reset, bus accesses read from the golden file,
 * sense interrupt polling for seeks, checks and watchdog
 */

`timescale 1ns/1ps

module fdc_ctrl_tb;

	localparam int          CLK_NS      = 8;
	localparam int          POLL_TRIES  = 100;
	localparam int          SEEK_CYCLES = 80 * 16 * fdc_pkg::STEP_CYCLES_PER_MS;
	localparam int          POLL_GAP    = SEEK_CYCLES / POLL_TRIES;
	localparam longint      MARGIN_NS   = 10_000_000;
	localparam logic [31:0] SEED        = 32'h771a1f6d;

	logic                       clk_sys;
	logic                       reset;
	logic                       a0;
	logic                       rd_n;
	logic                       wr_n;
	logic [7:0]                 din;
	logic [7:0]                 dout;
	fdc_pkg::drive_info_t [1:0] drive;

	string script [$];   // golden lines without comments
	int    seek_lines  = 0;
	bit    loaded      = 1'b0;
	string test_name   = "";
	bit    test_open   = 1'b0;
	int    test_checks = 0;
	int    test_errors = 0;
	int    tests       = 0;
	int    checks      = 0;
	int    errors      = 0;

	fdc_ctrl_top i_fdc_ctrl_top (
		.i_clk_sys (clk_sys),
		.i_reset   (reset),
		.i_a0      (a0),
		.i_rd_n    (rd_n),
		.i_wr_n    (wr_n),
		.i_din     (din),
		.i_drive   (drive),
		.o_dout    (dout)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_NS / 2) clk_sys = ~clk_sys;
	end

	// ==================================================================
	// bus accesses
	// ==================================================================

	task automatic idle_gap();
		int gap;
		gap = 2 + int'($urandom % 8);   // 2 to 9 clocks high
		repeat (gap) @(posedge clk_sys);
	endtask

	task automatic bus_write(input logic a0_v, input logic [7:0] data_v);
		@(posedge clk_sys);
		a0   <= a0_v;
		din  <= data_v;
		wr_n <= 1'b0;
		repeat (3) @(posedge clk_sys);
		wr_n <= 1'b1;
		idle_gap();
	endtask

	task automatic bus_read(input logic a0_v, output logic [7:0] data_v);
		@(posedge clk_sys);
		a0   <= a0_v;
		rd_n <= 1'b0;
		repeat (3) @(posedge clk_sys);   // dout valid 2 clocks after the fall
		@(negedge clk_sys);
		data_v = dout;
		@(posedge clk_sys);
		rd_n <= 1'b1;
		idle_gap();
	endtask

	// ==================================================================
	// checks and bookkeeping
	// ==================================================================

	task automatic check_byte(input string what, input logic [7:0] exp_v,
	                          input logic [7:0] act_v);
		checks++;
		test_checks++;
		if (act_v !== exp_v) begin
			errors++;
			test_errors++;
			$display("Fail %s %s: expected %02h, actual %02h", test_name, what, exp_v, act_v);
		end
	endtask

	task automatic close_test();
		if (test_open) begin
			tests++;
			$display("test %s: %0d checks, %0d errors", test_name, test_checks, test_errors);
		end
		test_open   = 1'b0;
		test_checks = 0;
		test_errors = 0;
	endtask

	task automatic report_bad_line(input int idx);
		errors++;
		test_errors++;
		$display("golden entry %0d could not be understood", idx);
	endtask

	// repeat sense interrupt until a drive reports, then compare both bytes
	task automatic poll_seek(input logic [7:0] exp_st0, input logic [7:0] exp_pcn);
		logic [7:0] st0;
		logic [7:0] pcn;
		int         tries;
		bit         done;
		tries = 0;
		done  = 1'b0;
		while (!done && tries < POLL_TRIES) begin
			bus_write(1'b1, 8'h08);
			bus_read(1'b1, st0);
			tries++;
			if (st0 != 8'h80) begin
				bus_read(1'b1, pcn);
				done = 1'b1;
			end else begin
				repeat (POLL_GAP) @(posedge clk_sys);
			end
		end
		if (!done) begin
			errors++;
			test_errors++;
			$display("test %s: the seek never finished after %0d polls", test_name, tries);
		end else begin
			check_byte("sense int st0", exp_st0, st0);
			check_byte("sense int pcn", exp_pcn, pcn);
		end
	endtask

	task automatic load_golden();
		int    fd;
		int    n;
		string line;
		fd = $fopen("tb/fdc_ctrl_golden.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("the golden file could not be opened");
		end else begin
			while (!$feof(fd)) begin
				n = $fgets(line, fd);
				if (n > 1 && line.getc(0) != "#") begin
					script.push_back(line);
					if (line.getc(0) == "S")
						seek_lines++;
				end
			end
			$fclose(fd);
		end
	endtask

	// ==================================================================
	// main sequence
	// ==================================================================

	initial begin
		string      line;
		byte        kind;
		int         n;
		logic [7:0] a0_v;
		logic [7:0] val_v;
		logic [7:0] pcn_v;
		logic [7:0] got;
		reset = 1'b1;
		a0    = 1'b0;
		rd_n  = 1'b1;
		wr_n  = 1'b1;
		din   = 8'h00;
		drive[0].ready         = 1'b1;
		drive[0].write_protect = 1'b0;
		drive[0].two_sided     = 1'b1;
		drive[0].track_count   = 8'd80;
		drive[1].ready         = 1'b1;
		drive[1].write_protect = 1'b1;
		drive[1].two_sided     = 1'b0;
		drive[1].track_count   = 8'd40;
		void'($urandom(SEED));
		load_golden();
		loaded = 1'b1;

		repeat (8) @(posedge clk_sys);
		reset <= 1'b0;
		repeat (4) @(posedge clk_sys);

		foreach (script[i]) begin
			line = script[i];
			kind = line.getc(0);
			case (kind)
				"T": begin
					close_test();
					n = $sscanf(line, "T %s", test_name);
					test_open = 1'b1;
					if (n != 1)
						report_bad_line(i);
				end
				"W": begin
					n = $sscanf(line, "W %h %h", a0_v, val_v);
					if (n != 2)
						report_bad_line(i);
					else
						bus_write(a0_v[0], val_v);
				end
				"R": begin
					n = $sscanf(line, "R %h %h", a0_v, val_v);
					if (n != 2) begin
						report_bad_line(i);
					end else begin
						bus_read(a0_v[0], got);
						check_byte($sformatf("read a0=%0d", a0_v[0]), val_v, got);
					end
				end
				"S": begin
					n = $sscanf(line, "S %h %h", val_v, pcn_v);
					if (n != 2)
						report_bad_line(i);
					else
						poll_seek(val_v, pcn_v);
				end
				default: report_bad_line(i);
			endcase
		end
		close_test();

		errors += i_fdc_ctrl_top.i_fdc_result_fifo.i_fdc_ctrl_asserts.assert_errors;
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

	// worst case seek time for every poll line, plus slack for bus traffic
	initial begin
		longint limit_ns;
		wait (loaded);
		limit_ns = longint'(seek_lines) * 80 * 16 * fdc_pkg::STEP_CYCLES_PER_MS * CLK_NS
			+ MARGIN_NS;
		#(limit_ns);
		$display("watchdog expired after %0d ns, the run did not finish", limit_ns);
		$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== fdc_ctrl.f ====
logic/fdc_pkg.sv
logic/fdc_host_port.sv
logic/fdc_result_fifo.sv
logic/fdc_command_sequencer.sv
logic/fdc_seek_engine.sv
logic/fdc_ctrl_top.sv
tb/fdc_ctrl_asserts.sv
tb/fdc_ctrl_tb.sv

// ==== tb/fdc_ctrl_golden.txt ====
# T name | W a0 byte (host write) | R a0 byte (read, expected value)
# S st0 pcn (poll sense interrupt until done, expected bytes), all values hex
T reset
R 0 80
R 1 FF
T invalid_opcode
W 1 1F
R 0 D0
R 1 80
R 0 80
T sense_int_idle
W 1 08
R 1 80
R 0 80
T recal_seek
W 1 03
W 1 F0
W 1 02
W 1 07
W 1 00
S 20 00
W 1 0F
W 1 01
W 1 0A
S 21 0A
W 1 0F
W 1 00
W 1 2D
R 0 81
S 20 2D
T seek_error
W 1 0F
W 1 01
W 1 30
S E9 0A
T sense_drive
W 1 04
W 1 01
R 1 61
W 1 07
W 1 00
S 20 00
W 1 04
W 1 00
R 1 38
R 0 80
